//--- Makefile
.PHONY: help test clean

help:
	@echo "test   build with Verilator and run the testbench"
	@echo "clean  remove build output"

test:
	verilator --binary --timing --assert -j 0 --top-module mips32Tb -f list.f -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

//--- list.f
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mips32.sv
testbench/mips32_sva.sv
testbench/mips32Tb.sv

//--- rtl/decodeStage.sv
// Instruction decode stage of the MIPS32 pipeline
// Decodes controls, reads the register file and fills the ID/EX register
// Stall and taken branch both turn the ID/EX entry into a bubble
`timescale 1ns/1ps

module decodeStage (
   input  logic              Clk,
   input  logic              rst,
   input  mipsPkg::word_t    idInstr,
   input  mipsPkg::word_t    idPc4,
   input  logic              stall,
   input  logic              branchTaken,
   input  logic              wbValid,
   input  mipsPkg::regAddr_t wbReg,
   input  mipsPkg::word_t    wbData,
   output logic              exRegWrite,
   output logic              exMemRead,
   output logic              exMemWrite,
   output logic              exMemToReg,
   output logic              exBranch,
   output logic              exAluSrc,
   output mipsPkg::aluOp_e   exAluOp,
   output mipsPkg::regAddr_t exRs,
   output mipsPkg::regAddr_t exRt,
   output mipsPkg::regAddr_t exDest,
   output mipsPkg::word_t    exDataA,
   output mipsPkg::word_t    exDataB,
   output mipsPkg::word_t    exImm,
   output mipsPkg::word_t    exPc4
);
   import mipsPkg::*;

   logic     regWrite, memRead, memWrite, memToReg, branch, aluSrc;
   aluOp_e   aluOp;
   regAddr_t dest;
   word_t    dataA, dataB, imm;

   registerFile regFile0 (
      .Clk      (Clk),
      .rst      (rst),
      .rdAddrA  (idInstr[25:21]),
      .rdAddrB  (idInstr[20:16]),
      .wrEnable (wbValid),
      .wrAddr   (wbReg),
      .wrData   (wbData),
      .rdDataA  (dataA),
      .rdDataB  (dataB)
   );

   assign imm = {{16{idInstr[15]}}, idInstr[15:0]};

   // Main control, unknown opcode or funct decodes as a no-op
   always_comb begin
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      memToReg = 1'b0;
      branch   = 1'b0;
      aluSrc   = 1'b0;
      aluOp    = ALU_ADD;
      dest     = '0;
      case (idInstr[31:26])
         OP_RTYPE: begin
            dest     = idInstr[15:11];
            regWrite = 1'b1;
            case (idInstr[5:0])
               FUNCT_ADD: aluOp = ALU_ADD;
               FUNCT_SUB: aluOp = ALU_SUB;
               FUNCT_AND: aluOp = ALU_AND;
               FUNCT_OR:  aluOp = ALU_OR;
               FUNCT_SLT: aluOp = ALU_SLT;
               default:   regWrite = 1'b0;
            endcase
         end
         OP_LW: begin
            // Load writes rt
            dest     = idInstr[20:16];
            regWrite = 1'b1;
            memRead  = 1'b1;
            memToReg = 1'b1;
            aluSrc   = 1'b1;
         end
         OP_SW: begin
            memWrite = 1'b1;
            aluSrc   = 1'b1;
         end
         OP_BEQ: begin
            branch = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // ID/EX controls and register numbers
   always_ff @(posedge Clk) begin
      if (rst || stall || branchTaken) begin
         exRegWrite <= 1'b0;
         exMemRead  <= 1'b0;
         exMemWrite <= 1'b0;
         exMemToReg <= 1'b0;
         exBranch   <= 1'b0;
         exAluSrc   <= 1'b0;
         exAluOp    <= ALU_ADD;
         exRs       <= '0;
         exRt       <= '0;
         exDest     <= '0;
      end else begin
         exRegWrite <= regWrite;
         exMemRead  <= memRead;
         exMemWrite <= memWrite;
         exMemToReg <= memToReg;
         exBranch   <= branch;
         exAluSrc   <= aluSrc;
         exAluOp    <= aluOp;
         exRs       <= idInstr[25:21];
         exRt       <= idInstr[20:16];
         exDest     <= dest;
      end
   end

   // ID/EX operands
   always_ff @(posedge Clk) begin
      exDataA <= dataA;
      exDataB <= dataB;
      exImm   <= imm;
      exPc4   <= idPc4;
   end

endmodule

//--- rtl/executeStage.sv
// Execute stage of the MIPS32 pipeline
// Forward muxes, immediate select, ALU and the beq decision
// branchTaken and branchTarget are combinational from ID/EX
// Results are registered into EX/MEM
`timescale 1ns/1ps

module executeStage (
   input  logic              Clk,
   input  logic              rst,
   input  logic              exRegWrite,
   input  logic              exMemRead,
   input  logic              exMemWrite,
   input  logic              exMemToReg,
   input  logic              exBranch,
   input  logic              exAluSrc,
   input  mipsPkg::aluOp_e   exAluOp,
   input  mipsPkg::regAddr_t exDest,
   input  mipsPkg::word_t    exDataA,
   input  mipsPkg::word_t    exDataB,
   input  mipsPkg::word_t    exImm,
   input  mipsPkg::word_t    exPc4,
   input  mipsPkg::fwdSel_e  fwdA,
   input  mipsPkg::fwdSel_e  fwdB,
   input  mipsPkg::word_t    wbData,
   output logic              branchTaken,
   output mipsPkg::word_t    branchTarget,
   output logic              memRegWrite,
   output logic              memMemRead,
   output logic              memMemWrite,
   output logic              memMemToReg,
   output mipsPkg::regAddr_t memDest,
   output mipsPkg::word_t    memAluResult,
   output mipsPkg::word_t    memStoreData
);
   import mipsPkg::*;

   word_t opA;
   word_t opB;
   word_t aluB;
   word_t aluResult;

   // One forward mux, used for both operands
   function automatic word_t fwdMux(fwdSel_e sel, word_t regVal, word_t memVal,
                                    word_t wbVal);
      case (sel)
         FWD_MEM: return memVal;
         FWD_WB:  return wbVal;
         default: return regVal;
      endcase
   endfunction

   assign opA = fwdMux(fwdA, exDataA, memAluResult, wbData);
   assign opB = fwdMux(fwdB, exDataB, memAluResult, wbData);

   // Immediate for lw and sw address
   assign aluB = exAluSrc ? exImm : opB;

   always_comb begin
      case (exAluOp)
         ALU_ADD: aluResult = opA + aluB;
         ALU_SUB: aluResult = opA - aluB;
         ALU_AND: aluResult = opA & aluB;
         ALU_OR:  aluResult = opA | aluB;
         ALU_SLT: aluResult = ($signed(opA) < $signed(aluB)) ? 32'd1 : 32'd0;
         default: aluResult = '0;
      endcase
   end

   // beq compares the forwarded register values
   assign branchTaken  = exBranch && (opA == opB);
   assign branchTarget = exPc4 + {exImm[29:0], 2'b00};

   // EX/MEM controls
   always_ff @(posedge Clk) begin
      if (rst) begin
         memRegWrite <= 1'b0;
         memMemRead  <= 1'b0;
         memMemWrite <= 1'b0;
         memMemToReg <= 1'b0;
         memDest     <= '0;
      end else begin
         memRegWrite <= exRegWrite;
         memMemRead  <= exMemRead;
         memMemWrite <= exMemWrite;
         memMemToReg <= exMemToReg;
         // Non-writing instructions carry r0
         memDest     <= exRegWrite ? exDest : '0;
      end
   end

   // EX/MEM data, store data is the forwarded rt
   always_ff @(posedge Clk) begin
      memAluResult <= aluResult;
      memStoreData <= opB;
   end

endmodule

//--- rtl/fetchStage.sv
// Instruction fetch stage of the MIPS32 pipeline
// Holds the PC, the instruction memory and the IF/ID register
// Instruction memory is loaded through the prog port while rst is high
// A taken branch redirects the PC and squashes the fetched word
`timescale 1ns/1ps

module fetchStage (
   input  logic                         Clk,
   input  logic                         rst,
   input  logic                         progWrite,
   input  logic [mipsPkg::IMEM_AW-1:0]  progAddr,
   input  mipsPkg::word_t               progData,
   input  logic                         stall,
   input  logic                         branchTaken,
   input  mipsPkg::word_t               branchTarget,
   output mipsPkg::word_t               idInstr,
   output mipsPkg::word_t               idPc4
);
   import mipsPkg::*;

   word_t pc;
   word_t pc4;
   word_t imem [IMEM_DEPTH];

   assign pc4 = pc + 32'd4;

   // Program load port
   always_ff @(posedge Clk) begin
      if (progWrite) begin
         imem[progAddr] <= progData;
      end
   end

   // Next PC, branch wins over stall
   always_ff @(posedge Clk) begin
      if (rst) begin
         pc <= '0;
      end else if (branchTaken) begin
         pc <= branchTarget;
      end else if (!stall) begin
         pc <= pc4;
      end
   end

   // IF/ID instruction, zero word is a no-op
   always_ff @(posedge Clk) begin
      if (rst) begin
         idInstr <= '0;
      end else if (branchTaken) begin
         idInstr <= '0;
      end else if (!stall) begin
         idInstr <= imem[pc[IMEM_AW+1:2]];
      end
   end

   // IF/ID payload
   always_ff @(posedge Clk) begin
      if (!stall) begin
         idPc4 <= pc4;
      end
   end

endmodule

//--- rtl/hazardUnit.sv
// Hazard detection and forwarding control for the MIPS32 pipeline
// Stalls one cycle when the instruction in ID uses a register still being loaded
// Picks MEM or WB results as execute operands, MEM taking priority
`timescale 1ns/1ps

module hazardUnit (
   input  mipsPkg::word_t    idInstr,
   input  logic              exRegWrite,
   input  logic              exMemRead,
   input  mipsPkg::regAddr_t exRs,
   input  mipsPkg::regAddr_t exRt,
   input  mipsPkg::regAddr_t exDest,
   input  logic              memRegWrite,
   input  mipsPkg::regAddr_t memDest,
   input  logic              wbValid,
   input  mipsPkg::regAddr_t wbReg,
   output logic              stall,
   output mipsPkg::fwdSel_e  fwdA,
   output mipsPkg::fwdSel_e  fwdB
);
   import mipsPkg::*;

   regAddr_t idRs;
   regAddr_t idRt;

   // Forward source for one execute operand
   function automatic fwdSel_e pickFwd(regAddr_t src, logic memWr, regAddr_t memRd,
                                       logic wbWr, regAddr_t wbRd);
      if (memWr && memRd != '0 && memRd == src) begin
         return FWD_MEM;
      end else if (wbWr && wbRd != '0 && wbRd == src) begin
         return FWD_WB;
      end
      return FWD_NONE;
   endfunction

   assign idRs = idInstr[25:21];
   assign idRt = idInstr[20:16];

   // Load in EX feeding the instruction in ID
   assign stall = exMemRead && exRegWrite && exDest != '0 &&
                  (exDest == idRs || exDest == idRt);

   assign fwdA = pickFwd(exRs, memRegWrite, memDest, wbValid, wbReg);
   assign fwdB = pickFwd(exRt, memRegWrite, memDest, wbValid, wbReg);

endmodule

//--- rtl/memoryStage.sv
// Memory stage of the MIPS32 pipeline
// Data memory with combinational read and clocked write
// Reports each store and fills the MEM/WB register that drives writeback
`timescale 1ns/1ps

module memoryStage (
   input  logic              Clk,
   input  logic              rst,
   input  logic              memRegWrite,
   input  logic              memMemRead,
   input  logic              memMemWrite,
   input  logic              memMemToReg,
   input  mipsPkg::regAddr_t memDest,
   input  mipsPkg::word_t    memAluResult,
   input  mipsPkg::word_t    memStoreData,
   output logic              storeValid,
   output mipsPkg::word_t    storeAddr,
   output mipsPkg::word_t    storeData,
   output logic              wbValid,
   output mipsPkg::regAddr_t wbReg,
   output mipsPkg::word_t    wbData
);
   import mipsPkg::*;

   word_t dmem [DMEM_DEPTH];
   word_t readData;

   // Data memory powers up as zero
   initial begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
         dmem[i] = '0;
      end
   end

   always_ff @(posedge Clk) begin
      if (memMemWrite) begin
         dmem[memAluResult[DMEM_AW+1:2]] <= memStoreData;
      end
   end

   assign readData = memMemRead ? dmem[memAluResult[DMEM_AW+1:2]] : '0;

   // Store report in the cycle the write happens
   assign storeValid = memMemWrite;
   assign storeAddr  = memAluResult;
   assign storeData  = memStoreData;

   // MEM/WB, writes to r0 retire silently
   always_ff @(posedge Clk) begin
      if (rst) begin
         wbValid <= 1'b0;
      end else begin
         wbValid <= memRegWrite && memDest != '0;
      end
   end

   always_ff @(posedge Clk) begin
      wbReg  <= memDest;
      wbData <= memMemToReg ? readData : memAluResult;
   end

endmodule

//--- rtl/mips32.sv
// Top level of the five-stage in-order MIPS32 pipeline
// Supports add, sub, and, or, slt, lw, sw and beq
// Load the program through the prog port while rst is high
// Every register write and every store is reported on the outputs
`timescale 1ns/1ps

module mips32 (
   input  logic                         Clk,
   input  logic                         rst,
   input  logic                         progWrite,
   input  logic [mipsPkg::IMEM_AW-1:0]  progAddr,
   input  mipsPkg::word_t               progData,
   output logic                         wbValid,
   output mipsPkg::regAddr_t            wbReg,
   output mipsPkg::word_t               wbData,
   output logic                         storeValid,
   output mipsPkg::word_t               storeAddr,
   output mipsPkg::word_t               storeData
);
   import mipsPkg::*;

   // IF/ID
   word_t    idInstr, idPc4;
   // Hazard and branch control
   logic     stall, branchTaken;
   word_t    branchTarget;
   fwdSel_e  fwdA, fwdB;
   // ID/EX
   logic     exRegWrite, exMemRead, exMemWrite, exMemToReg, exBranch, exAluSrc;
   aluOp_e   exAluOp;
   regAddr_t exRs, exRt, exDest;
   word_t    exDataA, exDataB, exImm, exPc4;
   // EX/MEM
   logic     memRegWrite, memMemRead, memMemWrite, memMemToReg;
   regAddr_t memDest;
   word_t    memAluResult, memStoreData;

   fetchStage fetch0 (
      .Clk (Clk), .rst (rst),
      .progWrite (progWrite), .progAddr (progAddr), .progData (progData),
      .stall (stall), .branchTaken (branchTaken), .branchTarget (branchTarget),
      .idInstr (idInstr), .idPc4 (idPc4)
   );

   decodeStage decode0 (
      .Clk (Clk), .rst (rst),
      .idInstr (idInstr), .idPc4 (idPc4),
      .stall (stall), .branchTaken (branchTaken),
      .wbValid (wbValid), .wbReg (wbReg), .wbData (wbData),
      .exRegWrite (exRegWrite), .exMemRead (exMemRead), .exMemWrite (exMemWrite),
      .exMemToReg (exMemToReg), .exBranch (exBranch), .exAluSrc (exAluSrc),
      .exAluOp (exAluOp), .exRs (exRs), .exRt (exRt), .exDest (exDest),
      .exDataA (exDataA), .exDataB (exDataB), .exImm (exImm), .exPc4 (exPc4)
   );

   hazardUnit hazard0 (
      .idInstr (idInstr),
      .exRegWrite (exRegWrite), .exMemRead (exMemRead),
      .exRs (exRs), .exRt (exRt), .exDest (exDest),
      .memRegWrite (memRegWrite), .memDest (memDest),
      .wbValid (wbValid), .wbReg (wbReg),
      .stall (stall), .fwdA (fwdA), .fwdB (fwdB)
   );

   executeStage execute0 (
      .Clk (Clk), .rst (rst),
      .exRegWrite (exRegWrite), .exMemRead (exMemRead), .exMemWrite (exMemWrite),
      .exMemToReg (exMemToReg), .exBranch (exBranch), .exAluSrc (exAluSrc),
      .exAluOp (exAluOp), .exDest (exDest),
      .exDataA (exDataA), .exDataB (exDataB), .exImm (exImm), .exPc4 (exPc4),
      .fwdA (fwdA), .fwdB (fwdB), .wbData (wbData),
      .branchTaken (branchTaken), .branchTarget (branchTarget),
      .memRegWrite (memRegWrite), .memMemRead (memMemRead),
      .memMemWrite (memMemWrite), .memMemToReg (memMemToReg),
      .memDest (memDest), .memAluResult (memAluResult), .memStoreData (memStoreData)
   );

   memoryStage memory0 (
      .Clk (Clk), .rst (rst),
      .memRegWrite (memRegWrite), .memMemRead (memMemRead),
      .memMemWrite (memMemWrite), .memMemToReg (memMemToReg),
      .memDest (memDest), .memAluResult (memAluResult), .memStoreData (memStoreData),
      .storeValid (storeValid), .storeAddr (storeAddr), .storeData (storeData),
      .wbValid (wbValid), .wbReg (wbReg), .wbData (wbData)
   );

endmodule

//--- rtl/mipsPkg.sv
// Shared types and constants for the five-stage MIPS32 pipeline
// Imported by every pipeline stage, the hazard unit and the top level
// The testbench uses the opcode and funct codes to assemble its programs
package mipsPkg;

   // Data and instruction word
   typedef logic [31:0] word_t;

   // Register number
   typedef logic [4:0] regAddr_t;

   // Opcodes, instruction bits 31:26
   localparam logic [5:0] OP_RTYPE = 6'd0;
   localparam logic [5:0] OP_LW    = 6'd35;
   localparam logic [5:0] OP_SW    = 6'd43;
   localparam logic [5:0] OP_BEQ   = 6'd4;

   // R-type funct codes, instruction bits 5:0
   localparam logic [5:0] FUNCT_ADD = 6'd32;
   localparam logic [5:0] FUNCT_SUB = 6'd34;
   localparam logic [5:0] FUNCT_AND = 6'd36;
   localparam logic [5:0] FUNCT_OR  = 6'd37;
   localparam logic [5:0] FUNCT_SLT = 6'd42;

   // ALU operation, resolved in decode
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } aluOp_e;

   // Operand source for the execute stage
   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_MEM,
      FWD_WB
   } fwdSel_e;

   // Memory sizes in words
   localparam int IMEM_DEPTH = 64;
   localparam int DMEM_DEPTH = 64;

   // Word index widths, byte address bits 7:2
   localparam int IMEM_AW = 6;
   localparam int DMEM_AW = 6;

endpackage

//--- rtl/registerFile.sv
// 32-entry register file with two combinational read ports
// A write in the same cycle passes through to the read ports
// Register 0 always reads zero and ignores writes
`timescale 1ns/1ps

module registerFile (
   input  logic              Clk,
   input  logic              rst,
   input  mipsPkg::regAddr_t rdAddrA,
   input  mipsPkg::regAddr_t rdAddrB,
   input  logic              wrEnable,
   input  mipsPkg::regAddr_t wrAddr,
   input  mipsPkg::word_t    wrData,
   output mipsPkg::word_t    rdDataA,
   output mipsPkg::word_t    rdDataB
);
   import mipsPkg::*;

   word_t regs [32];

   always_ff @(posedge Clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEnable && wrAddr != '0) begin
         regs[wrAddr] <= wrData;
      end
   end

   // r0 first, then write pass-through, then stored value
   assign rdDataA = (rdAddrA == '0) ? '0 :
                    (wrEnable && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (rdAddrB == '0) ? '0 :
                    (wrEnable && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

//--- testbench/mips32Tb.sv
// Testbench for the five-stage MIPS32 pipeline
// Loads each program through the prog port during reset and runs it on the DUT
// An instruction-set reference model gives the expected writeback and store events
// Events from the DUT are compared in program order as they appear
`timescale 1ns/1ps

module mips32Tb;
   import mipsPkg::*;

   logic                Clk;
   logic                rst;
   logic                progWrite;
   logic [IMEM_AW-1:0]  progAddr;
   word_t               progData;
   logic                wbValid;
   regAddr_t            wbReg;
   word_t               wbData;
   logic                storeValid;
   word_t               storeAddr;
   word_t               storeData;

   // Program under test and architectural data memory
   word_t prog [IMEM_DEPTH];
   int    progLen;
   word_t refMem [DMEM_DEPTH];
   // Expected events, kind 0 is a writeback, kind 1 a store
   bit    evKind [$];
   word_t evA [$];
   word_t evB [$];
   int    seed;
   int    budget;
   bit    running;
   word_t seedWords [8] = '{32'd7, 32'hfffffffb, 32'h12345678, 32'h80000000,
                            32'd3, 32'hffffffff, 32'h0f0f0f0f, 32'd100};

   mips32 dut0 (
      .Clk (Clk), .rst (rst),
      .progWrite (progWrite), .progAddr (progAddr), .progData (progData),
      .wbValid (wbValid), .wbReg (wbReg), .wbData (wbData),
      .storeValid (storeValid), .storeAddr (storeAddr), .storeData (storeData)
   );

   initial begin
      Clk = 1'b0;
      forever #4 Clk = ~Clk;
   end

   function automatic word_t encR(logic [5:0] funct, regAddr_t rd, regAddr_t rs, regAddr_t rt);
      return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic word_t encI(logic [5:0] op, regAddr_t rs, regAddr_t rt,
                                  logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic emit(word_t w);
      prog[progLen] = w;
      progLen++;
   endtask

   // Sequential ISA model, returns the number of executed instructions
   function automatic int referenceRun();
      word_t       regs [32];
      word_t       pc, pcNext, instr, a, b, imm, res, addr;
      regAddr_t    rs, rt, rd;
      int          count;
      bit          done;
      bit          writes;
      count = 0;
      done  = 1'b0;
      pc    = '0;
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      while (!done && count < 1000) begin
         instr  = prog[pc[IMEM_AW+1:2]];
         count++;
         rs     = instr[25:21];
         rt     = instr[20:16];
         rd     = instr[15:11];
         a      = regs[rs];
         b      = regs[rt];
         imm    = {{16{instr[15]}}, instr[15:0]};
         pcNext = pc + 32'd4;
         case (instr[31:26])
            OP_RTYPE: begin
               writes = 1'b1;
               res    = '0;
               case (instr[5:0])
                  FUNCT_ADD: res = a + b;
                  FUNCT_SUB: res = a - b;
                  FUNCT_AND: res = a & b;
                  FUNCT_OR:  res = a | b;
                  FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default:   writes = 1'b0;
               endcase
               // r0 writes are dropped silently
               if (writes && rd != '0) begin
                  regs[rd] = res;
                  evKind.push_back(1'b0);
                  evA.push_back(word_t'(rd));
                  evB.push_back(res);
               end
            end
            OP_LW: begin
               addr = a + imm;
               res  = refMem[addr[DMEM_AW+1:2]];
               if (rt != '0) begin
                  regs[rt] = res;
                  evKind.push_back(1'b0);
                  evA.push_back(word_t'(rt));
                  evB.push_back(res);
               end
            end
            OP_SW: begin
               addr = a + imm;
               refMem[addr[DMEM_AW+1:2]] = b;
               evKind.push_back(1'b1);
               evA.push_back(addr);
               evB.push_back(b);
            end
            OP_BEQ: begin
               if (a == b) begin
                  pcNext = pc + 32'd4 + {imm[29:0], 2'b00};
                  // Branch to itself ends the program
                  done   = (pcNext == pc);
               end
            end
            default: begin
            end
         endcase
         pc = pcNext;
      end
      return count;
   endfunction

   task automatic checkValue(string name, word_t expected, word_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   task automatic expectEvent(bit kind, word_t a, word_t b);
      bit    expKind;
      word_t expA, expB;
      if (evKind.size() == 0) begin
         $display("The DUT reported an event beyond the expected list");
         $display("Errors found");
         $fatal(1);
      end
      expKind = evKind.pop_front();
      expA    = evA.pop_front();
      expB    = evB.pop_front();
      if (expKind != kind) begin
         $display("The DUT reported a %s where a %s was expected",
                  kind ? "store" : "writeback", expKind ? "store" : "writeback");
         $display("Errors found");
         $fatal(1);
      end
      if (kind) begin
         checkValue("storeAddr", expA, a);
         checkValue("storeData", expB, b);
      end else begin
         checkValue("wbReg", expA, a);
         checkValue("wbData", expB, b);
      end
   endtask

   // Outputs settle after the rising edge, so sample on the falling one
   // Writeback is older than a store in MEM, so it goes first
   always @(negedge Clk) begin
      if (wbValid === 1'b1) begin
         expectEvent(1'b0, word_t'(wbReg), wbData);
      end
      if (storeValid === 1'b1) begin
         expectEvent(1'b1, storeAddr, storeData);
      end
   end

   // Watchdog, budget set per program
   initial begin
      forever begin
         @(negedge Clk);
         if (running) begin
            if (budget <= 0) begin
               $display("Timeout: the pipeline stopped reporting events");
               $display("Errors found");
               $fatal(1);
            end
            budget--;
         end
      end
   end

   // Reset, load, run until every expected event has been seen
   task automatic runProgram();
      int executed;
      executed = referenceRun();
      @(negedge Clk);
      rst = 1'b1;
      // Two trailing no-ops cover the fetches past the final beq
      for (int i = 0; i < progLen + 2; i++) begin
         @(negedge Clk);
         progWrite = 1'b1;
         progAddr  = i[IMEM_AW-1:0];
         progData  = (i < progLen) ? prog[i] : '0;
      end
      @(negedge Clk);
      progWrite = 1'b0;
      repeat (10) @(negedge Clk);
      budget  = 20 + 4 * executed;
      running = 1'b1;
      rst     = 1'b0;
      while (evKind.size() != 0) begin
         @(negedge Clk);
      end
      // Quiet tail, any extra event fails here
      repeat (8) @(negedge Clk);
      running = 1'b0;
      progLen = 0;
   endtask

   task automatic endLoop();
      emit(encI(OP_BEQ, 5'd0, 5'd0, 16'hffff));
   endtask

   initial begin
      int r;
      rst        = 1'b1;
      progWrite  = 1'b0;
      progAddr   = '0;
      progData   = '0;
      progLen    = 0;
      running    = 1'b0;
      budget     = 0;
      seed       = 13219;
      @(negedge Clk);
      // Preload data words, first eight hold chosen signed values
      for (int i = 0; i < DMEM_DEPTH; i++) begin
         refMem[i] = (i < 8) ? seedWords[i] : word_t'(i) * 32'h9e3779b1 + 32'h1234;
         dut0.memory0.dmem[i] = refMem[i];
      end

      // Dependent R-type chains with MEM and WB forwarding, slt on negatives
      emit(encI(OP_LW, 5'd0, 5'd1, 16'd0));
      emit(encI(OP_LW, 5'd0, 5'd3, 16'd8));
      emit(encI(OP_LW, 5'd0, 5'd4, 16'd12));
      emit(encI(OP_LW, 5'd0, 5'd2, 16'd4));
      emit(encR(FUNCT_ADD, 5'd5, 5'd1, 5'd2));
      emit(encR(FUNCT_SUB, 5'd6, 5'd5, 5'd1));
      emit(encR(FUNCT_AND, 5'd7, 5'd6, 5'd3));
      emit(encR(FUNCT_OR,  5'd8, 5'd5, 5'd7));
      emit(encR(FUNCT_SLT, 5'd9, 5'd2, 5'd1));
      emit(encR(FUNCT_SLT, 5'd10, 5'd4, 5'd2));
      emit(encR(FUNCT_SLT, 5'd11, 5'd1, 5'd2));
      emit(encR(FUNCT_ADD, 5'd12, 5'd9, 5'd10));
      endLoop();
      runProgram();

      // Stores then loads, same and different addresses, load-use stalls
      emit(encI(OP_LW, 5'd0, 5'd1, 16'd0));
      emit(encI(OP_LW, 5'd0, 5'd2, 16'd4));
      emit(encI(OP_SW, 5'd0, 5'd1, 16'd64));
      emit(encI(OP_SW, 5'd0, 5'd2, 16'd68));
      emit(encI(OP_LW, 5'd0, 5'd3, 16'd64));
      emit(encI(OP_LW, 5'd0, 5'd4, 16'd68));
      emit(encI(OP_SW, 5'd0, 5'd3, 16'd72));
      emit(encI(OP_LW, 5'd0, 5'd5, 16'd72));
      emit(encR(FUNCT_ADD, 5'd6, 5'd5, 5'd4));
      emit(encI(OP_LW, 5'd0, 5'd7, 16'd24));
      emit(encR(FUNCT_SUB, 5'd8, 5'd0, 5'd7));
      endLoop();
      runProgram();

      // Taken beq skips two, untaken beq falls through
      emit(encI(OP_LW, 5'd0, 5'd1, 16'd0));
      emit(encI(OP_LW, 5'd0, 5'd2, 16'd0));
      emit(encI(OP_BEQ, 5'd1, 5'd2, 16'd2));
      emit(encR(FUNCT_ADD, 5'd3, 5'd1, 5'd1));
      emit(encR(FUNCT_ADD, 5'd4, 5'd1, 5'd1));
      emit(encI(OP_BEQ, 5'd1, 5'd0, 16'd1));
      emit(encR(FUNCT_ADD, 5'd6, 5'd1, 5'd1));
      emit(encR(FUNCT_ADD, 5'd7, 5'd6, 5'd1));
      endLoop();
      runProgram();

      // Random mix over r0 to r4, registers seeded from memory first
      for (int i = 1; i < 5; i++) begin
         emit(encI(OP_LW, 5'd0, regAddr_t'(i), 16'(4 * i)));
      end
      for (int i = 0; i < 40; i++) begin
         r = $unsigned($random(seed)) % 7;
         if (r == 5) begin
            emit(encI(OP_LW, 5'd0, regAddr_t'($unsigned($random(seed)) % 5),
                      16'(4 * ($unsigned($random(seed)) % 16))));
         end else if (r == 6) begin
            emit(encI(OP_SW, 5'd0, regAddr_t'($unsigned($random(seed)) % 5),
                      16'(4 * ($unsigned($random(seed)) % 16))));
         end else begin
            emit(encR(r == 0 ? FUNCT_ADD : r == 1 ? FUNCT_SUB : r == 2 ? FUNCT_AND :
                      r == 3 ? FUNCT_OR : FUNCT_SLT,
                      regAddr_t'($unsigned($random(seed)) % 5),
                      regAddr_t'($unsigned($random(seed)) % 5),
                      regAddr_t'($unsigned($random(seed)) % 5)));
         end
      end
      endLoop();
      runProgram();

      $display("No errors");
      $finish;
   end

endmodule

//--- testbench/mips32_sva.sv
// Assertions on the MIPS32 pipeline, bound into the top level
// Cover load-use stall length, writeback register and reset quiet outputs
`timescale 1ns/1ps

module mips32Checks (
   input logic              Clk,
   input logic              rst,
   input logic              stall,
   input logic              wbValid,
   input mipsPkg::regAddr_t wbReg,
   input logic              storeValid
);
   import mipsPkg::*;

   // Load-use stall lasts exactly one cycle
   stallOnce: assert property (@(posedge Clk) disable iff (rst) stall |=> !stall)
      else $error("stall high on two consecutive cycles");

   // r0 writes never reach the report
   wbNonZero: assert property (@(posedge Clk) disable iff (rst) wbValid |-> wbReg != '0)
      else $error("wbValid with wbReg zero");

   // Second reset cycle onward, no events
   quietInReset: assert property (@(posedge Clk) rst ##1 rst |-> !wbValid && !storeValid)
      else $error("event reported during reset");

endmodule

bind mips32 mips32Checks sva0 (
   .Clk        (Clk),
   .rst        (rst),
   .stall      (stall),
   .wbValid    (wbValid),
   .wbReg      (wbReg),
   .storeValid (storeValid)
);
